//--- files.f
+incdir+.
pinmux_pad_pkg.sv
pinmux_reg_pkg.sv
pinmux_wb_regs.sv
pad_func_decode.sv
pad_out_drive.sv
pad_in_route.sv
pinmux_top.sv
tb_pinmux.sv

//--- Makefile
# Verilator build and run of the pin multiplexer testbench
SRCS := $(shell grep -v '^+' files.f)

obj_dir/Vtb_pinmux: files.f $(SRCS) tb_pinmux_checks.svh
	verilator --binary -f files.f --top-module tb_pinmux -o Vtb_pinmux

.PHONY: run clean

run: obj_dir/Vtb_pinmux
	./obj_dir/Vtb_pinmux | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- tb_pinmux_checks.svh
// --------------------
// Testbench checks for the pin multiplexer
// Typed compares, run stops at the first mismatch
// --------------------
`ifndef TB_PINMUX_CHECKS_SVH
`define TB_PINMUX_CHECKS_SVH

// Report the error, then end the run
task automatic stop_run(input string what);
  $display("%s", what);
  $display("*** TEST FAILED ***");
  $fatal(1, "run stopped on first error");
endtask

// Pad output and enable vectors
task automatic compare_pads(input string what, input logic [NUM_PADS-1:0] got,
                            input logic [NUM_PADS-1:0] exp);
  if (got !== exp) begin
    stop_run($sformatf("FAILED at %0t: %s is %06h, expected %06h", $time, what, got, exp));
  end
endtask

// Pad to peripheral bundle, field by field in the message
task automatic verify_periph_in(input string what, input periph_in_t got,
                                input periph_in_t exp);
  if (got !== exp) begin
    stop_run($sformatf("FAILED at %0t: %s rxd %b intr %b mosi %b scl %b sda %b, expected %b",
                       $time, what, got.uart_rxd, got.ext_intr, got.spim_mosi,
                       got.i2cm_clk_i, got.i2cm_data_i, exp));
  end
endtask

// Register readback words
task automatic expect_word(input string what, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    stop_run($sformatf("FAILED at %0t: %s is %08h, expected %08h", $time, what, got, exp));
  end
endtask

`endif

//--- tb_pinmux.sv
// --------------------
// Testbench for the pin multiplexer
// Table of register setups, pad and peripheral stimulus
// with expected pads, peripheral inputs and readbacks
// --------------------
`default_nettype none

module tb_pinmux
  import pinmux_pad_pkg::*;
  import pinmux_reg_pkg::*;
();

  // One table row
  typedef struct packed {
    logic [31:0]         mf;
    logic [31:0]         dir;
    logic [31:0]         gout;
    logic                hold;
    logic [NUM_PADS-1:0] pad_in;
    periph_out_t         pout;
    logic [NUM_PADS-1:0] exp_out;
    logic [NUM_PADS-1:0] exp_oen;
    periph_in_t          exp_pin;
    logic [31:0]         exp_gpio_in;
    logic [31:0]         exp_strap;
  } row_t;

  logic                mclk;
  logic                arst_n;
  wb_req_t             wb_req;
  wb_rsp_t             wb_rsp;
  periph_out_t         periph_out;
  periph_in_t          periph_in;
  logic [NUM_PADS-1:0] pad_in;
  logic [NUM_PADS-1:0] pad_out;
  logic [NUM_PADS-1:0] pad_oen;
  row_t                rows [$];

  pinmux_top dut (
    .mclk_i       (mclk),
    .arst_n_i     (arst_n),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .periph_out_i (periph_out),
    .periph_in_o  (periph_in),
    .pad_in_i     (pad_in),
    .pad_out_o    (pad_out),
    .pad_oen_o    (pad_oen)
  );

  `include "tb_pinmux_checks.svh"

  initial begin
    mclk = 1'b0;
    forever #10 mclk = ~mclk;
  end

  // --------------------
  // Bus access
  // --------------------
  // Called on a falling edge, returns on a falling edge
  task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    int waited;
    waited = 0;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    while (wb_rsp.ack !== 1'b1 && waited < 16) begin
      @(negedge mclk);
      waited++;
    end
    if (wb_rsp.ack !== 1'b1) stop_run("Timeout: Wishbone slave gave no ack within 16 cycles");
    // Ack one clock after the request
    if (waited != 1) begin
      stop_run($sformatf("FAILED at %0t: ack after %0d cycles, expected 1", $time, waited));
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;
    @(negedge mclk);
    if (wb_rsp.ack !== 1'b0) begin
      stop_run($sformatf("FAILED at %0t: ack held for more than one cycle", $time));
    end
  endtask

  task automatic write_reg(input logic [WB_ADR_W-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused_rd;
    bus_access(1'b1, adr, dat, unused_rd);
  endtask

  task automatic read_reg(input logic [WB_ADR_W-1:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, 32'h0, dat);
  endtask

  // --------------------
  // Stimulus and expected values
  // --------------------
  // mf, dir, gout, hold, pad_in, periph_out, pad_out, pad_oen, periph_in, gpio_in, strap
  function automatic void load_table();
    // Reset config, straps follow pads
    rows.push_back('{32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1, 23'h40_2105,
                     18'b00_000000_0_0000_0_0_0_0_0, 23'h00_0000, 23'h7F_FFFF,
                     7'b11_00_0_0_0, 32'h0022_6004, 32'h0000_1501});
    // Hold released, strap pads as GPIO, straps frozen
    rows.push_back('{32'h0000_0000, 32'h0032_4026, 32'h0006_4022, 1'b0, 23'h01_1028,
                     18'b00_000000_0_0000_0_0_0_0_0, 23'h01_1005, 23'h7E_CEDA,
                     7'b11_00_0_0_0, 32'h0014_0022, 32'h0000_1500});
    // All GPIO out, PC7 reads zero
    rows.push_back('{32'h0000_0000, 32'hFFFF_FFFF, 32'hAAAA_AAAA, 1'b0, 23'h7F_FFFF,
                     18'b00_000000_0_0000_0_0_0_0_0, 23'h55_5594, 23'h00_0000,
                     7'b11_00_0_0_0, 32'h00FF_7FFF, 32'h0000_1500});
    // PWM over CS, UART TX over GPIO, I2C enables
    rows.push_back('{32'hDEAD_FB1E, 32'h00FF_FFFF, 32'h0000_0000, 1'b0, 23'h20_0000,
                     18'b11_010100_0_1010_0_1_1_1_0, 23'h60_2224, 23'h40_000A,
                     7'b00_00_0_0_1, 32'h0000_1000, 32'h0000_1500});
    // Chip selects alone
    rows.push_back('{32'h0000_7800, 32'h0000_0000, 32'h0000_0000, 1'b0, 23'h60_4008,
                     18'b00_111111_0_1010_0_0_0_0_0, 23'h00_1100, 23'h7F_CCFF,
                     7'b11_00_0_0_0, 32'h0004_3008, 32'h0000_1500});
    // RX1 over INT0, INT1, SPI master over PWM5
    rows.push_back('{32'h0000_06E0, 32'h0000_0000, 32'h0000_0000, 1'b0, 23'h60_401C,
                     18'b10_100000_0_0000_1_0_0_0_0, 23'h00_8020, 23'h7E_7FDF,
                     7'b11_10_1_0_0, 32'h000E_3008, 32'h0000_1500});
    // INT0 on pad 3, I2C inputs
    rows.push_back('{32'h0000_8040, 32'h0000_0000, 32'h0000_0000, 1'b0, 23'h40_4008,
                     18'b00_000000_0_0000_0_0_0_1_1, 23'h20_0000, 23'h3F_FFFF,
                     7'b11_01_0_1_0, 32'h0004_2008, 32'h0000_1500});
    // Hold set again, strap pads forced in
    rows.push_back('{32'h0000_0000, 32'h00FF_FFFF, 32'h00FF_FFFF, 1'b1, 23'h01_0020,
                     18'b00_000000_0_0000_0_0_0_0_0, 23'h7E_CEDB, 23'h01_3124,
                     7'b11_00_0_0_0, 32'h0010_0020, 32'h0000_2201});
  endfunction

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    row_t        r;
    logic [31:0] rd;
    arst_n     = 1'b0;
    wb_req     = '0;
    pad_in     = '0;
    periph_out = '0;
    load_table();
    repeat (16) @(posedge mclk);
    @(negedge mclk);
    arst_n = 1'b1;
    @(negedge mclk);

    // Reset state, every pad released
    compare_pads("pad_oen after reset", pad_oen, {NUM_PADS{1'b1}});
    compare_pads("pad_out after reset", pad_out, '0);
    verify_periph_in("periph_in after reset", periph_in, 7'b11_00_0_0_0);
    if (wb_rsp.ack !== 1'b0) stop_run($sformatf("FAILED at %0t: ack high after reset", $time));

    foreach (rows[i]) begin
      r = rows[i];
      write_reg(REG_MULTI_FUNC, r.mf);
      write_reg(REG_GPIO_DIR, r.dir);
      write_reg(REG_GPIO_OUT, r.gout);
      write_reg(REG_STRAP, {31'b0, r.hold});
      pad_in     = r.pad_in;
      periph_out = r.pout;
      // One edge for strap capture
      @(negedge mclk);
      compare_pads($sformatf("row %0d pad_out", i), pad_out, r.exp_out);
      compare_pads($sformatf("row %0d pad_oen", i), pad_oen, r.exp_oen);
      verify_periph_in($sformatf("row %0d periph_in", i), periph_in, r.exp_pin);
      read_reg(REG_MULTI_FUNC, rd);
      expect_word($sformatf("row %0d multi_func", i), rd, r.mf & 32'h0000_FFFF);
      read_reg(REG_GPIO_DIR, rd);
      expect_word($sformatf("row %0d gpio_dir", i), rd, r.dir & 32'h00FF_FFFF);
      read_reg(REG_GPIO_OUT, rd);
      expect_word($sformatf("row %0d gpio_out", i), rd, r.gout & 32'h00FF_FFFF);
      read_reg(REG_GPIO_IN, rd);
      expect_word($sformatf("row %0d gpio_in", i), rd, r.exp_gpio_in);
      read_reg(REG_STRAP, rd);
      expect_word($sformatf("row %0d strap", i), rd, r.exp_strap);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- pinmux_top.sv
// --------------------
// Pin multiplexer top
// Register block, owner decode, output and input stages
// --------------------
`default_nettype none

module pinmux_top
  import pinmux_pad_pkg::*;
  import pinmux_reg_pkg::*;
(
  input  wire logic                mclk_i,
  input  wire logic                arst_n_i,
  input  wire wb_req_t             wb_req_i,
  output wb_rsp_t                  wb_rsp_o,
  input  wire periph_out_t         periph_out_i,
  output periph_in_t               periph_in_o,
  input  wire logic [NUM_PADS-1:0] pad_in_i,
  output logic [NUM_PADS-1:0]      pad_out_o,
  output logic [NUM_PADS-1:0]      pad_oen_o
);

  pinmux_cfg_t         cfg;
  pad_func_t           pad_func;
  logic [NUM_GPIO-1:0] gpio_in;

  // Configuration and strap capture
  pinmux_wb_regs u_regs (
    .mclk_i    (mclk_i),
    .arst_n_i  (arst_n_i),
    .wb_req_i  (wb_req_i),
    .wb_rsp_o  (wb_rsp_o),
    .pad_in_i  (pad_in_i),
    .gpio_in_i (gpio_in),
    .cfg_o     (cfg)
  );

  pad_func_decode u_decode (
    .cfg_i      (cfg),
    .pad_func_o (pad_func)
  );

  pad_out_drive u_out (
    .pad_func_i   (pad_func),
    .gpio_out_i   (cfg.gpio_out),
    .periph_out_i (periph_out_i),
    .pad_out_o    (pad_out_o),
    .pad_oen_o    (pad_oen_o)
  );

  pad_in_route u_in (
    .pad_func_i  (pad_func),
    .pad_in_i    (pad_in_i),
    .periph_in_o (periph_in_o),
    .gpio_in_o   (gpio_in)
  );

endmodule

`default_nettype wire

//--- pad_in_route.sv
// --------------------
// Pad input stage
// Every pad feeds its GPIO input bit
// Peripherals see a pad only when they own it
// --------------------
`default_nettype none

module pad_in_route
  import pinmux_pad_pkg::*;
(
  input  wire pad_func_t           pad_func_i,
  input  wire logic [NUM_PADS-1:0] pad_in_i,
  output periph_in_t               periph_in_o,
  output logic [NUM_GPIO-1:0]      gpio_in_o
);

  // GPIO input, PC7 stays zero
  always_comb begin
    gpio_in_o = '0;
    for (int p = 0; p < NUM_PADS; p++) begin
      gpio_in_o[PAD_GPIO_BIT[p]] = pad_in_i[p];
    end
  end

  // --------------------
  // Peripheral inputs
  // --------------------
  always_comb begin
    periph_in_o = PERIPH_IN_IDLE;
    for (int p = 0; p < NUM_PADS; p++) begin
      case (pad_func_i[p])
        FUNC_UART_RX0:     periph_in_o.uart_rxd[0] = pad_in_i[p];
        FUNC_UART_RX1:     periph_in_o.uart_rxd[1] = pad_in_i[p];
        FUNC_INT0:         periph_in_o.ext_intr[0] = pad_in_i[p];
        FUNC_INT1:         periph_in_o.ext_intr[1] = pad_in_i[p];
        FUNC_SPIM_MOSI_IN: periph_in_o.spim_mosi   = pad_in_i[p];
        // I2C lines read back the pad level
        FUNC_I2C_SDA:      periph_in_o.i2cm_data_i = pad_in_i[p];
        FUNC_I2C_SCL:      periph_in_o.i2cm_clk_i  = pad_in_i[p];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- pad_out_drive.sv
// --------------------
// Pad output stage
// Drives pad value and active-low enable per owner
// --------------------
`default_nettype none

module pad_out_drive
  import pinmux_pad_pkg::*;
(
  input  wire pad_func_t           pad_func_i,
  input  wire logic [NUM_GPIO-1:0] gpio_out_i,
  input  wire periph_out_t         periph_out_i,
  output logic [NUM_PADS-1:0]      pad_out_o,
  output logic [NUM_PADS-1:0]      pad_oen_o
);

  always_comb begin
    for (int p = 0; p < NUM_PADS; p++) begin
      // Driving owners by default
      pad_out_o[p] = 1'b0;
      pad_oen_o[p] = 1'b0;
      case (pad_func_i[p])
        FUNC_GPIO_OUT:      pad_out_o[p] = gpio_out_i[PAD_GPIO_BIT[p]];
        FUNC_UART_TX0:      pad_out_o[p] = periph_out_i.uart_txd[0];
        FUNC_UART_TX1:      pad_out_o[p] = periph_out_i.uart_txd[1];
        FUNC_PWM0:          pad_out_o[p] = periph_out_i.pwm_wfm[0];
        FUNC_PWM1:          pad_out_o[p] = periph_out_i.pwm_wfm[1];
        FUNC_PWM2:          pad_out_o[p] = periph_out_i.pwm_wfm[2];
        FUNC_PWM3:          pad_out_o[p] = periph_out_i.pwm_wfm[3];
        FUNC_PWM4:          pad_out_o[p] = periph_out_i.pwm_wfm[4];
        FUNC_PWM5:          pad_out_o[p] = periph_out_i.pwm_wfm[5];
        FUNC_SPIM_CS0:      pad_out_o[p] = periph_out_i.spim_ssn[0];
        FUNC_SPIM_CS1:      pad_out_o[p] = periph_out_i.spim_ssn[1];
        FUNC_SPIM_CS2:      pad_out_o[p] = periph_out_i.spim_ssn[2];
        FUNC_SPIM_CS3:      pad_out_o[p] = periph_out_i.spim_ssn[3];
        FUNC_SPIM_MISO_OUT: pad_out_o[p] = periph_out_i.spim_miso;
        FUNC_SPIM_SCK:      pad_out_o[p] = periph_out_i.spim_sck;
        // Open-drain style, peripheral owns the enable
        FUNC_I2C_SDA: begin
          pad_out_o[p] = periph_out_i.i2cm_data_o;
          pad_oen_o[p] = periph_out_i.i2cm_data_oen;
        end
        FUNC_I2C_SCL: begin
          pad_out_o[p] = periph_out_i.i2cm_clk_o;
          pad_oen_o[p] = periph_out_i.i2cm_clk_oen;
        end
        // Input owners, strap and plain input
        default: pad_oen_o[p] = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- pad_func_decode.sv
// --------------------
// Pad owner decode
// Picks one function per pad from the configuration
// Strap hold first, then peripherals, then GPIO
// --------------------
`default_nettype none

module pad_func_decode
  import pinmux_pad_pkg::*;
  import pinmux_reg_pkg::*;
(
  input  wire pinmux_cfg_t cfg_i,
  output pad_func_t        pad_func_o
);

  logic [5:0] pwm_enb;
  logic [1:0] int_enb;
  logic [1:0] uart_enb;
  logic       spim_enb;
  logic [3:0] cs_enb;
  logic       i2cm_enb;

  // Field split of the multi-function word
  assign pwm_enb  = cfg_i.multi_func[MF_PWM_MSB:MF_PWM_LSB];
  assign int_enb  = cfg_i.multi_func[MF_INT_MSB:MF_INT_LSB];
  assign uart_enb = cfg_i.multi_func[MF_UART_MSB:MF_UART_LSB];
  assign spim_enb = cfg_i.multi_func[MF_SPIM_BIT];
  assign cs_enb   = cfg_i.multi_func[MF_SPIM_CS_MSB:MF_SPIM_CS_LSB];
  assign i2cm_enb = cfg_i.multi_func[MF_I2CM_BIT];

  always_comb begin
    // Base owner is GPIO, direction picks in or out
    for (int p = 0; p < NUM_PADS; p++) begin
      if (cfg_i.gpio_dir[PAD_GPIO_BIT[p]]) pad_func_o[p] = FUNC_GPIO_OUT;
      else                                 pad_func_o[p] = FUNC_IN;
    end

    // PD0, UART0 receive
    if (uart_enb[0]) pad_func_o[1] = FUNC_UART_RX0;
    // PD1, UART0 transmit
    if (uart_enb[0]) pad_func_o[2] = FUNC_UART_TX0;
    // PD2, receive beats INT0
    if (uart_enb[1])     pad_func_o[3] = FUNC_UART_RX1;
    else if (int_enb[0]) pad_func_o[3] = FUNC_INT0;
    // PD3, PWM0 over INT1
    if (pwm_enb[0])      pad_func_o[4] = FUNC_PWM0;
    else if (int_enb[1]) pad_func_o[4] = FUNC_INT1;
    // PD4, UART1 transmit
    if (uart_enb[1]) pad_func_o[5] = FUNC_UART_TX1;

    // --------------------
    // PWM over chip select
    // --------------------
    if (pwm_enb[1])     pad_func_o[8] = FUNC_PWM1;
    else if (cs_enb[3]) pad_func_o[8] = FUNC_SPIM_CS3;
    if (pwm_enb[2])     pad_func_o[9] = FUNC_PWM2;
    else if (cs_enb[2]) pad_func_o[9] = FUNC_SPIM_CS2;
    if (pwm_enb[3])     pad_func_o[12] = FUNC_PWM3;
    else if (cs_enb[1]) pad_func_o[12] = FUNC_SPIM_CS1;
    if (pwm_enb[4])     pad_func_o[13] = FUNC_PWM4;
    else if (cs_enb[0]) pad_func_o[13] = FUNC_SPIM_CS0;

    // PB3, SPI master data in wins over PWM5
    if (spim_enb)        pad_func_o[14] = FUNC_SPIM_MOSI_IN;
    else if (pwm_enb[5]) pad_func_o[14] = FUNC_PWM5;
    // PB4 and PB5, SPI master data out and clock
    if (spim_enb) pad_func_o[15] = FUNC_SPIM_MISO_OUT;
    if (spim_enb) pad_func_o[16] = FUNC_SPIM_SCK;

    // PC4 and PC5, I2C master
    if (i2cm_enb) pad_func_o[21] = FUNC_I2C_SDA;
    if (i2cm_enb) pad_func_o[22] = FUNC_I2C_SCL;

    // Strap hold overrides everything on strap pads
    if (cfg_i.strap_hold) begin
      for (int s = 0; s < STRAP_W; s++) begin
        pad_func_o[STRAP_PADS[s]] = FUNC_STRAP;
      end
    end
  end

endmodule

`default_nettype wire

//--- pinmux_wb_regs.sv
// --------------------
// Pin multiplexer register block
// Wishbone classic slave, one-cycle ack
// Holds multi-function, GPIO and strap registers
// --------------------
`default_nettype none

module pinmux_wb_regs
  import pinmux_pad_pkg::*;
  import pinmux_reg_pkg::*;
(
  input  wire logic                mclk_i,
  input  wire logic                arst_n_i,
  input  wire wb_req_t             wb_req_i,
  output wb_rsp_t                  wb_rsp_o,
  input  wire logic [NUM_PADS-1:0] pad_in_i,
  input  wire logic [NUM_GPIO-1:0] gpio_in_i,
  output pinmux_cfg_t              cfg_o
);

  wb_state_e          state;
  pinmux_cfg_t        cfg_q;
  logic [STRAP_W-1:0] strap_pads;
  logic [STRAP_W-1:0] strap_q;
  logic               req;
  logic               take;
  logic [31:0]        rdata;
  logic [31:0]        rdata_q;

  assign req  = wb_req_i.cyc & wb_req_i.stb;
  // Access is taken on the edge that raises ack
  assign take = req & (state == WB_IDLE);

  // Strap pads in strap bit order
  always_comb begin
    for (int s = 0; s < STRAP_W; s++) begin
      strap_pads[s] = pad_in_i[STRAP_PADS[s]];
    end
  end

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    rdata = '0;
    case (wb_req_i.adr)
      REG_MULTI_FUNC: rdata = cfg_q.multi_func;
      REG_GPIO_DIR:   rdata[NUM_GPIO-1:0] = cfg_q.gpio_dir;
      REG_GPIO_OUT:   rdata[NUM_GPIO-1:0] = cfg_q.gpio_out;
      REG_GPIO_IN:    rdata[NUM_GPIO-1:0] = gpio_in_i;
      REG_STRAP: begin
        rdata[STRAP_HOLD_BIT]               = cfg_q.strap_hold;
        rdata[STRAP_VAL_LSB +: STRAP_W]     = strap_q;
      end
      default: rdata = '0;
    endcase
  end

  // --------------------
  // Bus FSM and writes
  // --------------------
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state            <= WB_IDLE;
      cfg_q.multi_func <= '0;
      cfg_q.gpio_dir   <= '0;
      cfg_q.gpio_out   <= '0;
      // Strap pads start as inputs
      cfg_q.strap_hold <= 1'b1;
    end else begin
      case (state)
        WB_IDLE: if (req) state <= WB_ACK;
        default: state <= WB_IDLE;
      endcase
      if (take && wb_req_i.we) begin
        case (wb_req_i.adr)
          REG_MULTI_FUNC: cfg_q.multi_func <= wb_req_i.dat & MF_USED_MASK;
          REG_GPIO_DIR:   cfg_q.gpio_dir   <= wb_req_i.dat[NUM_GPIO-1:0];
          REG_GPIO_OUT:   cfg_q.gpio_out   <= wb_req_i.dat[NUM_GPIO-1:0];
          REG_STRAP:      cfg_q.strap_hold <= wb_req_i.dat[STRAP_HOLD_BIT];
          default: ;
        endcase
      end
    end
  end

  // Read data held through the ack cycle
  always_ff @(posedge mclk_i) begin
    if (take) rdata_q <= rdata;
  end

  // Straps track the pads while held, frozen once released
  always_ff @(posedge mclk_i) begin
    if (cfg_q.strap_hold) strap_q <= strap_pads;
  end

  assign wb_rsp_o.ack = (state == WB_ACK);
  assign wb_rsp_o.dat = rdata_q;
  assign cfg_o        = cfg_q;

endmodule

`default_nettype wire

//--- pinmux_reg_pkg.sv
// --------------------
// Register-side definitions for the pin multiplexer
// Addresses, multi-function fields, Wishbone bundles
// --------------------
`default_nettype none

package pinmux_reg_pkg;

  import pinmux_pad_pkg::NUM_GPIO;

  localparam int WB_ADR_W = 3;

  // Word addresses
  localparam logic [WB_ADR_W-1:0] REG_MULTI_FUNC = 3'd0;
  localparam logic [WB_ADR_W-1:0] REG_GPIO_DIR   = 3'd1;
  localparam logic [WB_ADR_W-1:0] REG_GPIO_OUT   = 3'd2;
  localparam logic [WB_ADR_W-1:0] REG_GPIO_IN    = 3'd3;
  localparam logic [WB_ADR_W-1:0] REG_STRAP      = 3'd4;

  // Multi-function word layout
  localparam int MF_PWM_LSB     = 0;
  localparam int MF_PWM_MSB     = 5;
  localparam int MF_INT_LSB     = 6;
  localparam int MF_INT_MSB     = 7;
  localparam int MF_UART_LSB    = 8;
  localparam int MF_UART_MSB    = 9;
  localparam int MF_SPIM_BIT    = 10;
  localparam int MF_SPIM_CS_LSB = 11;
  localparam int MF_SPIM_CS_MSB = 14;
  localparam int MF_I2CM_BIT    = 15;
  localparam logic [31:0] MF_USED_MASK = 32'h0000_FFFF;

  // Strap register layout
  localparam int STRAP_HOLD_BIT = 0;
  localparam int STRAP_VAL_LSB  = 8;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [31:0]         dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [31:0]         multi_func;
    logic [NUM_GPIO-1:0] gpio_dir;
    logic [NUM_GPIO-1:0] gpio_out;
    logic                strap_hold;
  } pinmux_cfg_t;

  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_e;

endpackage

`default_nettype wire

//--- pinmux_pad_pkg.sv
// --------------------
// Pad-side definitions for the pin multiplexer
// Pad count, strap pads, pad to GPIO bit map,
// pad owner encoding and peripheral signal bundles
// --------------------
`default_nettype none

package pinmux_pad_pkg;

  // Arduino-style pads, pad p sits on digital_io[p+5]
  localparam int NUM_PADS = 23;
  // Ports B, C and D, PC7 has no pad
  localparam int NUM_GPIO = 24;
  localparam int STRAP_W  = 6;

  // Strap bit order, strap[0] first
  localparam int unsigned STRAP_PADS [STRAP_W] = '{2, 5, 8, 12, 13, 16};

  // GPIO bit per pad
  // Port B at 7:0, port C at 15:8, port D at 23:16
  localparam int unsigned PAD_GPIO_BIT [NUM_PADS] = '{
    14, 16, 17, 18, 19, 20, 6, 7,
    21, 22, 23, 0, 1, 2, 3, 4,
    5, 8, 9, 10, 11, 12, 13
  };

  // --------------------
  // Pad owner
  // --------------------
  typedef enum logic [4:0] {
    FUNC_IN,
    FUNC_GPIO_OUT,
    FUNC_STRAP,
    FUNC_UART_RX0, FUNC_UART_RX1, FUNC_UART_TX0, FUNC_UART_TX1,
    FUNC_INT0, FUNC_INT1,
    FUNC_PWM0, FUNC_PWM1, FUNC_PWM2, FUNC_PWM3, FUNC_PWM4, FUNC_PWM5,
    FUNC_SPIM_CS0, FUNC_SPIM_CS1, FUNC_SPIM_CS2, FUNC_SPIM_CS3,
    FUNC_SPIM_MOSI_IN, FUNC_SPIM_MISO_OUT, FUNC_SPIM_SCK,
    FUNC_I2C_SDA, FUNC_I2C_SCL
  } pad_func_e;

  // One owner per pad
  typedef pad_func_e [NUM_PADS-1:0] pad_func_t;

  // --------------------
  // Peripheral bundles
  // --------------------
  // Peripherals toward pads
  typedef struct packed {
    logic [1:0] uart_txd;
    logic [5:0] pwm_wfm;
    logic       spim_sck;
    logic [3:0] spim_ssn;
    logic       spim_miso;
    logic       i2cm_clk_o;
    logic       i2cm_clk_oen;
    logic       i2cm_data_o;
    logic       i2cm_data_oen;
  } periph_out_t;

  // Pads toward peripherals
  typedef struct packed {
    logic [1:0] uart_rxd;
    logic [1:0] ext_intr;
    logic       spim_mosi;
    logic       i2cm_clk_i;
    logic       i2cm_data_i;
  } periph_in_t;

  // Idle levels, UART receive lines rest high
  localparam periph_in_t PERIPH_IN_IDLE = '{
    uart_rxd:    2'b11,
    ext_intr:    2'b00,
    spim_mosi:   1'b0,
    i2cm_clk_i:  1'b0,
    i2cm_data_i: 1'b0
  };

endpackage

`default_nettype wire
